/* hw/lc4_isa_pkg.sv */
package lc4_isa_pkg;

  typedef logic [15:0] word_t;     // One machine word
  typedef logic [2:0]  reg_idx_t;  // R0..R7
  typedef logic [2:0]  nzp_t;      // {n, z, p}

  // Kept opcodes, everything else decodes as a no-op
  typedef enum logic [3:0] {
    OP_BR    = 4'b0000,
    OP_ARITH = 4'b0001,
    OP_LOGIC = 4'b0101,
    OP_LDR   = 4'b0110,
    OP_STR   = 4'b0111,
    OP_CONST = 4'b1001
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_NOT    = 4'd5,
    ALU_PASS_B = 4'd6,  // CONST
    ALU_ADDR   = 4'd7   // Base register plus offset for LDR/STR
  } alu_op_e;

  // One instruction word, four field layouts
  typedef union packed {
    struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic [2:0] subop;     // Bit 2 is the immediate flag
      reg_idx_t   rt;
    } rrr;
    struct packed {
      opcode_e    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic       imm_flag;
      logic [4:0] imm5;
    } ri;
    struct packed {
      opcode_e    opcode;
      reg_idx_t   rd_rt;     // rd for LDR, rt for STR
      reg_idx_t   rs;
      logic [5:0] imm6;
    } mem;
    struct packed {
      opcode_e    opcode;
      nzp_t       nzp;       // Branch mask
      logic [8:0] imm9;
    } br;
  } lc4_insn_u;

  function automatic word_t sext5(input logic [4:0] v);
    return {{11{v[4]}}, v};
  endfunction

  function automatic word_t sext6(input logic [5:0] v);
    return {{10{v[5]}}, v};
  endfunction

  function automatic word_t sext9(input logic [8:0] v);
    return {{7{v[8]}}, v};
  endfunction

  // Condition bits of a written value
  function automatic nzp_t nzp_of(input word_t w);
    return {w[15], w == 16'h0000, !w[15] && (w != 16'h0000)};
  endfunction

endpackage

/* hw/lc4_pipe_pkg.sv */
package lc4_pipe_pkg;

  // Stall code carried with every record, NONE marks a real instruction
  typedef enum logic [1:0] {
    STALL_NONE     = 2'd0,
    STALL_FLUSH    = 2'd2,  // Branch flush and reset bubble
    STALL_LOAD_USE = 2'd3
  } stall_e;

  typedef struct packed {
    logic                  rs_re;
    logic                  rt_re;      // Also set for store data
    logic                  rf_we;
    logic                  nzp_we;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    lc4_isa_pkg::alu_op_e  alu_op;
  } ctrl_t;

  // Decode to execute
  typedef struct packed {
    lc4_isa_pkg::word_t    pc;
    lc4_isa_pkg::word_t    insn;
    ctrl_t                 ctrl;
    lc4_isa_pkg::reg_idx_t rs;
    lc4_isa_pkg::reg_idx_t rt;
    lc4_isa_pkg::reg_idx_t rd;
    lc4_isa_pkg::word_t    imm;        // Sign-extended immediate or offset
    stall_e                stall;
  } dx_t;

  // Execute to memory, also reused for memory to writeback
  typedef struct packed {
    lc4_isa_pkg::word_t    pc;
    lc4_isa_pkg::word_t    insn;
    ctrl_t                 ctrl;
    lc4_isa_pkg::reg_idx_t rd;
    lc4_isa_pkg::word_t    result;     // ALU result or memory address
    lc4_isa_pkg::word_t    mem_data;   // Store data, later the memory word
    lc4_isa_pkg::nzp_t     nzp;
    stall_e                stall;
  } xm_t;

  typedef struct packed {
    logic                  we;
    lc4_isa_pkg::reg_idx_t wsel;
    lc4_isa_pkg::word_t    data;
    logic                  nzp_we;
    lc4_isa_pkg::nzp_t     nzp;
  } wb_t;

  typedef struct packed {
    stall_e                stall;
    lc4_isa_pkg::word_t    pc;
    lc4_isa_pkg::word_t    insn;
    logic                  rf_we;
    lc4_isa_pkg::reg_idx_t rf_wsel;
    lc4_isa_pkg::word_t    rf_data;
    logic                  nzp_we;
    lc4_isa_pkg::nzp_t     nzp;
    logic                  dmem_we;
    lc4_isa_pkg::word_t    dmem_addr;
    lc4_isa_pkg::word_t    dmem_data;
  } retire_t;

endpackage

/* hw/lc4_regfile.sv */
`timescale 1ns/1ps

module lc4_regfile (
  input  logic                  gwe,
  input  logic                  i_arst_n,
  input  lc4_isa_pkg::reg_idx_t i_rs,
  input  lc4_isa_pkg::reg_idx_t i_rt,
  input  lc4_pipe_pkg::wb_t     i_wb,
  output lc4_isa_pkg::word_t    o_rs_data,
  output lc4_isa_pkg::word_t    o_rt_data
);
  import lc4_isa_pkg::*;

  word_t regs_q [8];  // R0..R7

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      regs_q <= '{default: '0};
    end else if (i_wb.we) begin
      regs_q[i_wb.wsel] <= i_wb.data;
    end
  end

  // Write-through, a read of the register being written sees the new value
  assign o_rs_data = (i_wb.we && i_wb.wsel == i_rs) ? i_wb.data : regs_q[i_rs];
  assign o_rt_data = (i_wb.we && i_wb.wsel == i_rt) ? i_wb.data : regs_q[i_rt];

endmodule

/* hw/lc4_decode.sv */
`timescale 1ns/1ps

module lc4_decode #(
  parameter lc4_isa_pkg::word_t RESET_PC = 16'h0000
) (
  input  logic               gwe,
  input  logic               i_arst_n,
  input  lc4_isa_pkg::word_t i_imem_insn,
  input  logic               i_redirect_valid,
  input  lc4_isa_pkg::word_t i_redirect_pc,
  output lc4_isa_pkg::word_t o_imem_addr,
  output lc4_pipe_pkg::dx_t  o_dx
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  word_t     pc_q;
  lc4_insn_u insn;
  ctrl_t     ctrl;
  reg_idx_t  rs;
  reg_idx_t  rt;
  reg_idx_t  rd;
  word_t     imm;
  logic      alu_grp;   // Register-writing ALU instruction
  logic      load_use;
  dx_t       dx_d;
  dx_t       dx_q;

  assign insn        = i_imem_insn;
  assign o_imem_addr = pc_q;  // Fetch is combinational
  assign o_dx        = dx_q;

  always_comb begin
    ctrl    = '0;
    alu_grp = 1'b0;
    rs      = insn.rrr.rs;
    rt      = insn.rrr.rt;
    rd      = insn.rrr.rd;
    imm     = '0;
    case (insn.rrr.opcode)
      OP_ARITH: begin
        alu_grp = 1'b1;
        imm     = sext5(insn.ri.imm5);
        if (insn.ri.imm_flag) ctrl.alu_op = ALU_ADD;
        else if (insn.rrr.subop == 3'b000) ctrl.alu_op = ALU_ADD;
        else if (insn.rrr.subop == 3'b010) ctrl.alu_op = ALU_SUB;
        else alu_grp = 1'b0;  // MUL and DIV
      end
      OP_LOGIC: begin
        alu_grp = 1'b1;
        imm     = sext5(insn.ri.imm5);
        if (insn.ri.imm_flag) ctrl.alu_op = ALU_AND;
        else begin
          case (insn.rrr.subop)
            3'b000:  ctrl.alu_op = ALU_AND;
            3'b001:  ctrl.alu_op = ALU_NOT;
            3'b010:  ctrl.alu_op = ALU_OR;
            default: ctrl.alu_op = ALU_XOR;  // 3'b011, imm flag clear
          endcase
        end
      end
      OP_LDR: begin
        rd           = insn.mem.rd_rt;
        rs           = insn.mem.rs;
        imm          = sext6(insn.mem.imm6);
        ctrl.rs_re   = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.nzp_we  = 1'b1;
        ctrl.is_load = 1'b1;
        ctrl.alu_op  = ALU_ADDR;
      end
      OP_STR: begin
        rt            = insn.mem.rd_rt;  // Data to store
        rs            = insn.mem.rs;
        imm           = sext6(insn.mem.imm6);
        ctrl.rs_re    = 1'b1;
        ctrl.rt_re    = 1'b1;
        ctrl.is_store = 1'b1;
        ctrl.alu_op   = ALU_ADDR;
      end
      OP_CONST: begin
        imm         = sext9(insn.br.imm9);
        ctrl.rf_we  = 1'b1;
        ctrl.nzp_we = 1'b1;
        ctrl.alu_op = ALU_PASS_B;
      end
      OP_BR: begin
        imm            = sext9(insn.br.imm9);
        ctrl.is_branch = |insn.br.nzp;  // Empty mask is the NOP
      end
      default: ;  // Dropped opcodes retire with no writes
    endcase
    if (alu_grp) begin
      ctrl.rs_re  = 1'b1;
      ctrl.rt_re  = !insn.ri.imm_flag && (ctrl.alu_op != ALU_NOT);
      ctrl.rf_we  = 1'b1;
      ctrl.nzp_we = 1'b1;
    end
  end

  // Load in execute feeding the word in decode, stores only need rs
  assign load_use = dx_q.ctrl.is_load &&
                    ((ctrl.rs_re && rs == dx_q.rd) ||
                     (ctrl.rt_re && !ctrl.is_store && rt == dx_q.rd) ||
                     ctrl.is_branch);  // Branch needs the load's NZP

  always_comb begin
    dx_d       = '0;
    dx_d.stall = STALL_FLUSH;                           // Killed by a taken branch
    if (!i_redirect_valid) begin
      if (load_use) dx_d.stall = STALL_LOAD_USE;
      else begin
        dx_d.pc    = pc_q;
        dx_d.insn  = i_imem_insn;
        dx_d.ctrl  = ctrl;
        dx_d.rs    = rs;
        dx_d.rt    = rt;
        dx_d.rd    = rd;
        dx_d.imm   = imm;
        dx_d.stall = STALL_NONE;
      end
    end
  end

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q       <= RESET_PC;
      dx_q       <= '0;
      dx_q.stall <= STALL_FLUSH;  // Reset bubble
    end else begin
      if (i_redirect_valid) pc_q <= i_redirect_pc;
      else if (!load_use) pc_q <= pc_q + 16'd1;  // Hold PC and word while stalled
      dx_q <= dx_d;
    end
  end

  // Redirect comes from a branch in execute, which can never be the load that stalls us
  a_no_redirect_in_stall: assert property (@(posedge gwe) disable iff (!i_arst_n)
    !(i_redirect_valid && load_use));

endmodule

/* hw/lc4_execute.sv */
`timescale 1ns/1ps

module lc4_execute (
  input  logic               gwe,
  input  logic               i_arst_n,
  input  lc4_pipe_pkg::dx_t  i_dx,
  input  lc4_pipe_pkg::wb_t  i_wb,
  output lc4_pipe_pkg::xm_t  o_xm,
  output logic               o_redirect_valid,
  output lc4_isa_pkg::word_t o_redirect_pc
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  lc4_insn_u x_insn;
  word_t     rf_rs;
  word_t     rf_rt;
  word_t     rs_val;     // Operands after bypass
  word_t     rt_val;
  word_t     b_val;
  word_t     alu_res;
  nzp_t      nzp_q;      // Architectural NZP, written at writeback
  nzp_t      br_nzp;     // NZP as the branch should see it
  xm_t       xm_d;
  xm_t       xm_q;

  // Memory stage first unless it is a load, then writeback, then the register file
  function automatic word_t fwd(input reg_idx_t idx, input word_t rf_val,
                                input xm_t xm, input wb_t wb);
    if (xm.ctrl.rf_we && !xm.ctrl.is_load && xm.rd == idx) begin
      return xm.result;
    end
    if (wb.we && wb.wsel == idx) begin
      return wb.data;
    end
    return rf_val;
  endfunction

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_arst_n  (i_arst_n),
    .i_rs      (i_dx.rs),
    .i_rt      (i_dx.rt),
    .i_wb      (i_wb),
    .o_rs_data (rf_rs),
    .o_rt_data (rf_rt)
  );

  assign x_insn = i_dx.insn;
  assign rs_val = fwd(i_dx.rs, rf_rs, xm_q, i_wb);
  assign rt_val = fwd(i_dx.rt, rf_rt, xm_q, i_wb);
  assign b_val  = i_dx.ctrl.rt_re ? rt_val : i_dx.imm;  // Register or immediate form

  always_comb begin
    case (i_dx.ctrl.alu_op)
      ALU_ADD:    alu_res = rs_val + b_val;
      ALU_SUB:    alu_res = rs_val - b_val;
      ALU_AND:    alu_res = rs_val & b_val;
      ALU_OR:     alu_res = rs_val | b_val;
      ALU_XOR:    alu_res = rs_val ^ b_val;
      ALU_NOT:    alu_res = ~rs_val;
      ALU_PASS_B: alu_res = b_val;
      ALU_ADDR:   alu_res = rs_val + i_dx.imm;  // Ignores rt, which is store data
      default:    alu_res = '0;
    endcase
  end

  // Youngest older NZP writer wins
  always_comb begin
    if (xm_q.ctrl.nzp_we) br_nzp = xm_q.nzp;
    else if (i_wb.nzp_we) br_nzp = i_wb.nzp;
    else br_nzp = nzp_q;
  end

  assign o_redirect_valid = i_dx.ctrl.is_branch && |(x_insn.br.nzp & br_nzp);
  assign o_redirect_pc    = i_dx.pc + 16'd1 + i_dx.imm;  // PC-relative target

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) nzp_q <= '0;
    else if (i_wb.nzp_we) nzp_q <= i_wb.nzp;
  end

  always_comb begin
    xm_d          = '0;
    xm_d.pc       = i_dx.pc;
    xm_d.insn     = i_dx.insn;
    xm_d.ctrl     = i_dx.ctrl;  // Bubbles arrive with ctrl already clear
    xm_d.rd       = i_dx.rd;
    xm_d.result   = alu_res;
    xm_d.mem_data = rt_val;      // Store data
    xm_d.nzp      = nzp_of(alu_res);
    xm_d.stall    = i_dx.stall;
  end

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      xm_q       <= '0;
      xm_q.stall <= STALL_FLUSH;
    end else begin
      xm_q <= xm_d;
    end
  end

  assign o_xm = xm_q;

  // Decode never builds a record that is both a load and a store
  a_load_store_excl: assert property (@(posedge gwe) disable iff (!i_arst_n)
    !(i_dx.ctrl.is_load && i_dx.ctrl.is_store));

endmodule

/* hw/lc4_result.sv */
`timescale 1ns/1ps

module lc4_result (
  input  logic                  gwe,
  input  logic                  i_arst_n,
  input  lc4_pipe_pkg::xm_t     i_xm,
  input  lc4_isa_pkg::word_t    i_dmem_rdata,
  output lc4_isa_pkg::word_t    o_dmem_addr,
  output logic                  o_dmem_we,
  output lc4_isa_pkg::word_t    o_dmem_wdata,
  output lc4_pipe_pkg::wb_t     o_wb,
  output lc4_pipe_pkg::retire_t o_retire
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  lc4_insn_u m_insn;
  logic      st_fwd;     // Store data produced by the load now in writeback
  word_t     m_data;
  xm_t       mw_q;       // mem_data holds the memory word here
  word_t     wb_data;

  assign m_insn       = i_xm.insn;
  assign st_fwd       = o_wb.we && o_wb.wsel == m_insn.mem.rd_rt;
  assign o_dmem_we    = i_xm.ctrl.is_store;
  assign o_dmem_addr  = (i_xm.ctrl.is_load || i_xm.ctrl.is_store) ? i_xm.result : '0;
  assign o_dmem_wdata = st_fwd ? o_wb.data : i_xm.mem_data;

  // Word that goes with the access, zero for non-memory instructions
  assign m_data = i_xm.ctrl.is_load  ? i_dmem_rdata :
                  i_xm.ctrl.is_store ? o_dmem_wdata : '0;

  always_ff @(posedge gwe or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mw_q       <= '0;
      mw_q.stall <= STALL_FLUSH;
    end else begin
      mw_q          <= i_xm;
      mw_q.mem_data <= m_data;
    end
  end

  assign wb_data = mw_q.ctrl.is_load ? mw_q.mem_data : mw_q.result;

  always_comb begin
    o_wb        = '0;
    o_wb.we     = mw_q.ctrl.rf_we;
    o_wb.nzp_we = mw_q.ctrl.nzp_we;
    if (mw_q.ctrl.rf_we) begin
      o_wb.wsel = mw_q.rd;
      o_wb.data = wb_data;
    end
    if (mw_q.ctrl.nzp_we) o_wb.nzp = mw_q.ctrl.is_load ? nzp_of(wb_data) : mw_q.nzp;
  end

  always_comb begin
    o_retire.stall     = mw_q.stall;
    o_retire.pc        = mw_q.pc;
    o_retire.insn      = mw_q.insn;
    o_retire.rf_we     = o_wb.we;
    o_retire.rf_wsel   = o_wb.wsel;
    o_retire.rf_data   = o_wb.data;
    o_retire.nzp_we    = o_wb.nzp_we;
    o_retire.nzp       = o_wb.nzp;
    o_retire.dmem_we   = mw_q.ctrl.is_store;
    o_retire.dmem_addr = (mw_q.ctrl.is_load || mw_q.ctrl.is_store) ? mw_q.result : '0;
    o_retire.dmem_data = mw_q.mem_data;
  end

  // Bubbles from flush, stall or reset never reach the data memory as writes
  a_no_bubble_store: assert property (@(posedge gwe) disable iff (!i_arst_n)
    o_dmem_we |-> i_xm.stall == STALL_NONE);

endmodule

/* hw/lc4_core.sv */
`timescale 1ns/1ps

module lc4_core #(
  parameter lc4_isa_pkg::word_t RESET_PC = 16'h8200
) (
  input  logic                  gwe,
  input  logic                  i_arst_n,
  input  lc4_isa_pkg::word_t    i_imem_insn,
  input  lc4_isa_pkg::word_t    i_dmem_rdata,
  output lc4_isa_pkg::word_t    o_imem_addr,
  output lc4_isa_pkg::word_t    o_dmem_addr,
  output logic                  o_dmem_we,
  output lc4_isa_pkg::word_t    o_dmem_wdata,
  output lc4_pipe_pkg::retire_t o_retire
);
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  dx_t   dx;              // Decode to execute
  xm_t   xm;              // Execute to memory
  wb_t   wb;              // Writeback back to execute
  logic  redirect_valid;  // Taken branch
  word_t redirect_pc;

  lc4_decode #(
    .RESET_PC (RESET_PC)
  ) u_decode (
    .gwe              (gwe),
    .i_arst_n         (i_arst_n),
    .i_imem_insn      (i_imem_insn),
    .i_redirect_valid (redirect_valid),
    .i_redirect_pc    (redirect_pc),
    .o_imem_addr      (o_imem_addr),
    .o_dx             (dx)
  );

  lc4_execute u_execute (
    .gwe              (gwe),
    .i_arst_n         (i_arst_n),
    .i_dx             (dx),
    .i_wb             (wb),
    .o_xm             (xm),
    .o_redirect_valid (redirect_valid),
    .o_redirect_pc    (redirect_pc)
  );

  lc4_result u_result (
    .gwe          (gwe),
    .i_arst_n     (i_arst_n),
    .i_xm         (xm),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wdata (o_dmem_wdata),
    .o_wb         (wb),
    .o_retire     (o_retire)
  );

endmodule

/* testbench/lc4_ref_model.svh */
`ifndef LC4_REF_MODEL_SVH
`define LC4_REF_MODEL_SVH

// Low bits of v as a signed field of the given width
function automatic word_t sign_extend(input word_t v, input int bits);
  word_t shifted;
  shifted = v << (16 - bits);
  return $signed(shifted) >>> (16 - bits);
endfunction

// Sign of the value as a two's complement number
function automatic nzp_t nzp_bits(input word_t v);
  return {$signed(v) < 0, v == 16'h0000, $signed(v) > 0};
endfunction

// Program word at a PC, a NOP outside the loaded program
function automatic word_t fetch_word(input word_t addr);
  int off;
  off = int'(word_t'(addr - RESET_PC));
  if (off < prog_len) return imem[off];
  return 16'h0000;
endfunction

// True when word w reads register ld or is a real branch
function automatic logic waits_on_load(input word_t w, input logic [2:0] ld);
  logic rs_hit;
  logic rt_hit;
  rs_hit = (w[8:6] == ld);
  rt_hit = (w[2:0] == ld);
  case (w[15:12])
    4'b0001: begin
      if (w[5]) return rs_hit;
      else if (!w[3]) return rs_hit || rt_hit;  // ADD, SUB
      else return 1'b0;                         // Dropped MUL, DIV
    end
    4'b0101: begin
      if (w[5] || w[4:3] == 2'b01) return rs_hit;  // Immediate AND, NOT
      else return rs_hit || rt_hit;
    end
    4'b0110, 4'b0111: return rs_hit;  // Store data never stalls
    4'b0000: return w[11:9] != 3'b000;
    default: return 1'b0;
  endcase
endfunction

// Executes the instruction at m_pc and returns its retire record
function automatic retire_t ref_step();
  retire_t    r;
  word_t      w;
  word_t      a;
  word_t      b;
  word_t      res;
  word_t      addr;
  word_t      nxt;
  logic       wr;
  logic [2:0] rd;
  w          = fetch_word(m_pc);
  rd         = w[11:9];
  a          = m_regs[w[8:6]];
  b          = w[5] ? sign_extend(w, 5) : m_regs[w[2:0]];
  r          = '0;
  r.stall    = STALL_NONE;
  r.pc       = m_pc;
  r.insn     = w;
  res        = '0;
  wr         = 1'b0;
  nxt        = m_pc + 16'd1;
  exp_bubble = STALL_NONE;
  case (w[15:12])
    4'b0001: begin
      wr = w[5] || !w[3];
      res = (!w[5] && w[4]) ? a - b : a + b;
    end
    4'b0101: begin
      wr = 1'b1;
      if (w[5]) res = a & b;
      else begin
        case (w[4:3])
          2'b00:   res = a & b;
          2'b01:   res = ~a;
          2'b10:   res = a | b;
          default: res = a ^ b;
        endcase
      end
    end
    4'b0110: begin
      addr        = a + sign_extend(w, 6);
      res         = m_mem[addr];
      wr          = 1'b1;
      r.dmem_addr = addr;
      r.dmem_data = res;
    end
    4'b0111: begin
      addr         = a + sign_extend(w, 6);
      r.dmem_we    = 1'b1;
      r.dmem_addr  = addr;
      r.dmem_data  = m_regs[rd];
      m_mem[addr]  = m_regs[rd];
    end
    4'b1001: begin
      res = sign_extend(w, 9);
      wr  = 1'b1;
    end
    4'b0000: begin
      if ((w[11:9] & m_nzp) != 3'b000) begin
        nxt        = m_pc + 16'd1 + sign_extend(w, 9);
        exp_bubble = STALL_FLUSH;  // Word behind a taken branch dies
      end
    end
    default: ;
  endcase
  if (wr) begin
    r.rf_we    = 1'b1;
    r.rf_wsel  = rd;
    r.rf_data  = res;
    r.nzp_we   = 1'b1;
    r.nzp      = nzp_bits(res);
    m_regs[rd] = res;
    m_nzp      = r.nzp;
  end
  if (w[15:12] == 4'b0110 && waits_on_load(fetch_word(nxt), rd)) begin
    exp_bubble = STALL_LOAD_USE;
  end
  m_pc = nxt;
  return r;
endfunction

`endif

/* testbench/tb_lc4_core.sv */
`timescale 1ns/1ps

module tb_lc4_core;
  import lc4_isa_pkg::*;
  import lc4_pipe_pkg::*;

  localparam word_t RESET_PC  = 16'h8200;
  localparam int    IMEM_SIZE = 512;
  localparam int    RAND_LEN  = 300;
  localparam int    ARITH = 1;  // Opcodes for the encoders
  localparam int    LOGIC = 5;
  localparam int    LDR   = 6;
  localparam int    STR   = 7;

  logic    gwe;
  logic    i_arst_n;
  word_t   i_imem_insn;
  word_t   i_dmem_rdata;
  word_t   o_imem_addr;
  word_t   o_dmem_addr;
  logic    o_dmem_we;
  word_t   o_dmem_wdata;
  retire_t o_retire;

  word_t   imem [IMEM_SIZE];  // Offset from RESET_PC
  word_t   dmem [65536];
  int      prog_len;
  word_t   prog_end;

  word_t   m_pc;              // Reference model state
  word_t   m_regs [8];
  nzp_t    m_nzp;
  word_t   m_mem [65536];
  stall_e  exp_bubble;        // Bubble expected before the next retire

  logic    mem_port_we;       // Data memory port one edge back
  word_t   mem_port_addr;
  word_t   mem_port_wdata;

  integer  seed;
  int      total_insns;
  int      timeout_limit;
  int      cycle_count;
  int      run_cycles;
  logic    first_retired;
  logic    test_done;

  `include "lc4_ref_model.svh"

  lc4_core #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .gwe          (gwe),
    .i_arst_n     (i_arst_n),
    .i_imem_insn  (i_imem_insn),
    .i_dmem_rdata (i_dmem_rdata),
    .o_imem_addr  (o_imem_addr),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wdata (o_dmem_wdata),
    .o_retire     (o_retire)
  );

  initial begin
    gwe = 1'b0;
    forever #5 gwe = ~gwe;
  end

  always_comb i_imem_insn = fetch_word(o_imem_addr);  // Combinational fetch
  always_comb i_dmem_rdata = dmem[o_dmem_addr];

  // Only the store itself is in the memory stage at this edge
  always @(posedge gwe) begin
    if (o_dmem_we) dmem[o_dmem_addr] = o_dmem_wdata;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_bubble(input stall_e code);
    check_value("o_retire.stall", 32'(o_retire.stall), 32'(code));
    check_value("o_retire.rf_we", 32'(o_retire.rf_we), 0);
    check_value("o_retire.nzp_we", 32'(o_retire.nzp_we), 0);
    check_value("o_retire.dmem_we", 32'(o_retire.dmem_we), 0);
    check_value("o_dmem_we", 32'(mem_port_we), 0);  // Bubble passed the memory port idle
    check_value("o_dmem_addr", 32'(mem_port_addr), 0);
  endtask

  task automatic compare_retire();
    retire_t exp;
    exp = ref_step();
    check_value("o_retire.stall", 32'(o_retire.stall), 32'(exp.stall));
    check_value("o_retire.pc", 32'(o_retire.pc), 32'(exp.pc));
    check_value("o_retire.insn", 32'(o_retire.insn), 32'(exp.insn));
    check_value("o_retire.rf_we", 32'(o_retire.rf_we), 32'(exp.rf_we));
    check_value("o_retire.rf_wsel", 32'(o_retire.rf_wsel), 32'(exp.rf_wsel));
    check_value("o_retire.rf_data", 32'(o_retire.rf_data), 32'(exp.rf_data));
    check_value("o_retire.nzp_we", 32'(o_retire.nzp_we), 32'(exp.nzp_we));
    check_value("o_retire.nzp", 32'(o_retire.nzp), 32'(exp.nzp));
    check_value("o_retire.dmem_we", 32'(o_retire.dmem_we), 32'(exp.dmem_we));
    check_value("o_retire.dmem_addr", 32'(o_retire.dmem_addr), 32'(exp.dmem_addr));
    check_value("o_retire.dmem_data", 32'(o_retire.dmem_data), 32'(exp.dmem_data));
    // Memory port as driven while this instruction was in the memory stage
    check_value("o_dmem_we", 32'(mem_port_we), 32'(exp.dmem_we));
    check_value("o_dmem_addr", 32'(mem_port_addr), 32'(exp.dmem_addr));
    if (exp.dmem_we) begin
      check_value("o_dmem_wdata", 32'(mem_port_wdata), 32'(exp.dmem_data));
    end
  endtask

  // Compare process, sampled before the edge updates anything
  always @(posedge gwe) begin
    if (i_arst_n && !test_done) begin
      run_cycles++;
      cycle_count++;
      if (cycle_count > timeout_limit) begin
        $display("Errors found");
        $fatal(1, "Timeout: the run did not finish within %0d cycles", timeout_limit);
      end else begin
        if (!first_retired) begin
          if (o_retire.stall == STALL_NONE) begin
            check_value("first retire cycle", run_cycles, 4);
            first_retired = 1'b1;
            compare_retire();
          end else begin
            check_bubble(STALL_FLUSH);  // Reset bubbles still draining
          end
        end else if (exp_bubble != STALL_NONE) begin
          check_bubble(exp_bubble);
          exp_bubble = STALL_NONE;
        end else begin
          compare_retire();
        end
        if (first_retired && m_pc >= prog_end) test_done = 1'b1;
      end
    end
    mem_port_we    = o_dmem_we;  // Checked when this instruction retires
    mem_port_addr  = o_dmem_addr;
    mem_port_wdata = o_dmem_wdata;
  end

  function automatic word_t enc_reg(input int op, input int sub, input int rd,
                                    input int rs, input int rt);
    return {op[3:0], rd[2:0], rs[2:0], sub[2:0], rt[2:0]};
  endfunction

  function automatic word_t enc_imm(input int op, input int rd, input int rs, input int imm);
    return {op[3:0], rd[2:0], rs[2:0], 1'b1, imm[4:0]};
  endfunction

  function automatic word_t enc_mem(input int op, input int r, input int rs, input int off);
    return {op[3:0], r[2:0], rs[2:0], off[5:0]};
  endfunction

  function automatic word_t enc_const(input int rd, input int imm);
    return {4'b1001, rd[2:0], imm[8:0]};
  endfunction

  function automatic word_t enc_br(input int mask, input int off);
    return {4'b0000, mask[2:0], off[8:0]};
  endfunction

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // Holds reset 5 cycles, fills memories and restarts the model
  task automatic reset_core();
    int i;
    int a;
    @(posedge gwe);
    i_arst_n <= 1'b0;
    for (i = 0; i < 5; i++) begin
      @(posedge gwe);
      if (i == 0) begin
        test_done = 1'b0;
        for (a = 0; a < 65536; a++) begin
          dmem[a]  = {a[7:0], a[15:8]} ^ 16'h5a3c;
          m_mem[a] = {a[7:0], a[15:8]} ^ 16'h5a3c;
        end
        m_regs        = '{default: '0};
        m_pc          = RESET_PC;
        m_nzp         = '0;
        exp_bubble    = STALL_NONE;
        first_retired = 1'b0;
        run_cycles    = 0;
        prog_end      = RESET_PC + word_t'(prog_len);
        total_insns   = total_insns + prog_len;
        timeout_limit = 2 * total_insns + 20;  // Grows with each loaded program
      end
      check_value("o_dmem_we", 32'(o_dmem_we), 0);
      check_value("o_imem_addr", 32'(o_imem_addr), 32'(RESET_PC));
      check_value("o_retire.stall", 32'(o_retire.stall), 32'(STALL_FLUSH));
    end
    i_arst_n <= 1'b1;
  endtask

  task automatic run_program();
    reset_core();
    wait (test_done == 1'b1);
  endtask

  // Back-to-back dependences hit memory bypass, writeback bypass and write-through
  task automatic load_alu_program();
    prog_len = 0;
    emit(enc_const(1, 5));
    emit(enc_const(2, -3));
    emit(enc_reg(ARITH, 0, 3, 1, 2));
    emit(enc_reg(ARITH, 2, 4, 3, 1));
    emit(enc_reg(LOGIC, 0, 5, 4, 2));
    emit(enc_reg(LOGIC, 2, 6, 5, 1));
    emit(enc_reg(LOGIC, 3, 7, 6, 3));
    emit(enc_reg(LOGIC, 1, 0, 7, 0));
    emit(enc_imm(ARITH, 1, 0, -7));
    emit(enc_imm(LOGIC, 2, 1, 13));
    emit(enc_const(3, 255));
    emit(enc_reg(ARITH, 0, 4, 1, 3));
    emit(enc_reg(LOGIC, 3, 5, 5, 5));
    emit(enc_reg(ARITH, 0, 6, 5, 5));
    emit(enc_reg(ARITH, 2, 7, 6, 1));
  endtask

  task automatic load_mem_program();
    prog_len = 0;
    emit(enc_const(1, 64));
    emit(enc_const(2, 77));
    emit(enc_mem(STR, 2, 1, 0));
    emit(enc_mem(STR, 1, 1, 5));
    emit(enc_const(3, -9));
    emit(enc_mem(STR, 3, 1, -2));
    emit(enc_mem(LDR, 4, 1, 0));
    emit(enc_reg(ARITH, 0, 5, 4, 4));  // Load-use on rs and rt
    emit(enc_mem(LDR, 6, 1, 5));
    emit(enc_mem(LDR, 7, 6, -2));      // Load-use through the base
    emit(enc_reg(LOGIC, 1, 0, 7, 0));
    emit(enc_mem(LDR, 2, 1, 20));      // Untouched fill word
    emit(enc_mem(STR, 2, 1, 21));      // Store data from a load, no stall
    emit(enc_mem(LDR, 3, 1, 21));
    emit(enc_mem(LDR, 3, 1, -2));
    emit(enc_br(4, 1));                // Load then branch, stall and flush
    emit(enc_const(4, 1));
    emit(enc_reg(ARITH, 0, 5, 3, 3));
  endtask

  task automatic load_branch_program();
    prog_len = 0;
    emit(enc_const(1, 0));
    emit(enc_br(2, 2));   // BRz taken
    emit(enc_const(2, 1));
    emit(enc_const(2, 2));
    emit(enc_br(5, 1));   // BRnp not taken
    emit(enc_const(3, -4));
    emit(enc_br(4, 0));   // Taken to the next word
    emit(enc_imm(ARITH, 3, 3, 4));
    emit(enc_br(1, 3));   // BRp not taken
    emit(enc_br(2, 1));
    emit(enc_const(4, 7));
    emit(enc_const(5, 3));
    emit(enc_br(7, 2));
    emit(enc_reg(LOGIC, 1, 6, 5, 0));
    emit(enc_reg(LOGIC, 1, 7, 5, 0));
    emit(enc_br(0, 5));   // Empty mask is a NOP
    emit(enc_reg(ARITH, 0, 6, 5, 5));
  endtask

  task automatic load_random_program();
    logic [31:0] r;
    logic [31:0] v;
    int          i;
    int          rd;
    int          rs;
    int          rt;
    prog_len = 0;
    for (i = 0; i < RAND_LEN; i++) begin
      r  = $random(seed);
      v  = $random(seed);
      rd = int'(r[6:4]);
      rs = int'(r[9:7]);
      rt = int'(r[12:10]);
      case (r[3:0])
        4'd0:          emit(enc_reg(ARITH, 0, rd, rs, rt));
        4'd1:          emit(enc_reg(ARITH, 2, rd, rs, rt));
        4'd2:          emit(enc_reg(LOGIC, 0, rd, rs, rt));
        4'd3:          emit(enc_reg(LOGIC, 2, rd, rs, rt));
        4'd4:          emit(enc_reg(LOGIC, 3, rd, rs, rt));
        4'd5:          emit(enc_reg(LOGIC, 1, rd, rs, rt));
        4'd6:          emit(enc_imm(ARITH, rd, rs, int'(v)));
        4'd7:          emit(enc_imm(LOGIC, rd, rs, int'(v)));
        4'd8, 4'd15:   emit(enc_const(rd, int'(v)));
        4'd9, 4'd10:   emit(enc_mem(LDR, rd, rs, int'(v)));
        4'd11, 4'd12:  emit(enc_mem(STR, rd, rs, int'(v)));
        default:       emit(enc_br(int'(v[2:0]), int'(v[5:3])));  // Forward only
      endcase
    end
  endtask

  initial begin
    i_arst_n       = 1'b0;
    seed           = 32'h22aa_228f;
    total_insns    = 0;
    timeout_limit  = 20;
    cycle_count    = 0;
    run_cycles     = 0;
    first_retired  = 1'b0;
    test_done      = 1'b1;  // Compare process idle until a program runs
    prog_len       = 0;
    exp_bubble     = STALL_NONE;
    mem_port_we    = 1'b0;
    mem_port_addr  = '0;
    mem_port_wdata = '0;
    load_alu_program();
    run_program();
    load_mem_program();
    run_program();
    load_branch_program();
    run_program();
    load_random_program();
    run_program();
    $display("No errors");
    $finish;
  end

endmodule

/* lc4_core.f */
hw/lc4_isa_pkg.sv
hw/lc4_pipe_pkg.sv
hw/lc4_regfile.sv
hw/lc4_decode.sv
hw/lc4_execute.sv
hw/lc4_result.sv
hw/lc4_core.sv
+incdir+testbench
testbench/tb_lc4_core.sv

/* Makefile */
TOP := tb_lc4_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f lc4_core.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
